// File: design/soc_params.svh
// SoC fabric parameters
// Bus widths, address map, SRAM size and debug timing

`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 64
`define SOC_BE_W   8

// --------------------------------------------------
// Address map
// --------------------------------------------------
`define SOC_ROM_BASE  32'h0001_0000
`define SOC_ROM_LEN   32'h0000_1000
`define SOC_GPIO_BASE 32'h4000_0000
`define SOC_GPIO_LEN  32'h0000_1000
`define SOC_SRAM_BASE 32'h8000_0000

// 64-bit words, 4 KiB in total
`define SOC_SRAM_WORDS 512

`define SOC_ROM_MAGIC 32'hB007_C0DE

// Debug hold window and reset synchroniser depth
`define SOC_DBG_HOLD        64
`define SOC_RST_SYNC_STAGES 2

`endif

// File: design/soc_pkg.sv
// SoC fabric package
// Response codes, region index and the payloads of the SRAM delay path

`include "soc_params.svh"

package soc_pkg;

  // AXI-style response encoding
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  typedef enum logic [1:0] {
    REG_ROM,
    REG_SRAM,
    REG_GPIO,
    REG_NONE
  } region_e;

  // Request toward the SRAM, 105 bits
  typedef struct packed {
    logic [`SOC_ADDR_W-1:0] addr;
    logic                   we;
    logic [`SOC_BE_W-1:0]   be;
    logic [`SOC_DATA_W-1:0] wdata;
  } mem_req_t;

  // Response from the SRAM, 66 bits
  typedef struct packed {
    logic [`SOC_DATA_W-1:0] data;
    resp_e                  resp;
  } mem_rsp_t;

endpackage

// File: design/delay_stage.sv
// Delay stage
// One-entry valid/ready register slice, reused for request and
// response payloads on the SRAM path

module delay_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     valid_q;
  logic     load;
  payload_t data_q;

  // Slot is free, or the held item leaves this cycle
  assign in_ready_o = !valid_q || out_ready_i;
  assign load       = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

  // Stalled item stays in place
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

// File: design/sram_mem.sv
// SRAM model
// Word memory with byte-enable writes, one response held until taken

`include "soc_params.svh"

module sram_mem import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  mem_req_t req_i,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,
  output mem_rsp_t rsp_o
);

  localparam int unsigned OffW = $clog2(`SOC_BE_W);
  localparam int unsigned IdxW = $clog2(`SOC_SRAM_WORDS);

  logic [`SOC_DATA_W-1:0] mem_q [`SOC_SRAM_WORDS];
  logic [IdxW-1:0]        idx;
  logic                   req_fire;
  logic                   rsp_valid_q;
  mem_rsp_t               rsp_q;

  assign idx         = req_i.addr[OffW +: IdxW];
  assign req_ready_o = !rsp_valid_q || rsp_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;

  // Byte-masked write, read data or zero on the response
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      if (req_i.we) begin
        for (int b = 0; b < `SOC_BE_W; b++) begin
          if (req_i.be[b]) begin
            mem_q[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
          end
        end
      end
      rsp_q.data <= req_i.we ? '0 : mem_q[idx];
      rsp_q.resp <= OKAY;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else if (req_ready_o) begin
      rsp_valid_q <= req_valid_i;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

// File: design/boot_rom.sv
// Boot ROM
// Pattern ROM, one cycle latency, always ready; writes get SLVERR

`include "soc_params.svh"

module boot_rom import soc_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_valid_i,
  input  logic [`SOC_ADDR_W-1:0] req_addr_i,
  input  logic                   req_we_i,
  output logic                   rsp_valid_o,
  output logic [`SOC_DATA_W-1:0] rsp_data_o,
  output resp_e                  rsp_resp_o
);

  localparam int unsigned OffW  = $clog2(`SOC_BE_W);
  localparam int unsigned IdxW  = $clog2(`SOC_ROM_LEN / `SOC_BE_W);
  localparam int unsigned HalfW = `SOC_DATA_W / 2;

  logic [IdxW-1:0]        word_idx;
  logic [`SOC_DATA_W-1:0] pattern;

  // Base is aligned to the ROM size
  assign word_idx = req_addr_i[OffW +: IdxW];
  // Magic word above, word index below
  assign pattern  = {`SOC_ROM_MAGIC, HalfW'(word_idx)};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rsp_data_o <= req_we_i ? '0 : pattern;
      rsp_resp_o <= req_we_i ? SLVERR : OKAY;
    end
  end

endmodule

// File: design/debug_ctrl.sv
// Debug control
// Turns ndmreset into a synchronised fabric reset and holds off
// debug requests for a fixed window after power-on reset

`include "soc_params.svh"

module debug_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic fabric_rst_no,
  output logic debug_req_o
);

  localparam int unsigned Stages = `SOC_RST_SYNC_STAGES;
  localparam int unsigned CntW   = $clog2(`SOC_DBG_HOLD + 1);

  logic              sync_rst_n;
  logic [Stages-1:0] sync_q;
  logic [CntW-1:0]   hold_cnt_q;

  // --------------------------------------------------
  // Fabric reset with async assert and synchronous release
  // --------------------------------------------------
  assign sync_rst_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[Stages-2:0], 1'b1};
    end
  end

  assign fabric_rst_no = sync_q[Stages-1];

  // --------------------------------------------------
  // Debug request gating on power-on reset only
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_cnt_q <= CntW'(`SOC_DBG_HOLD);
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (hold_cnt_q == '0) && debug_req_i && debug_en_i;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (hold_cnt_q != '0) |-> !debug_req_o);

endmodule

// File: design/bus_decoder.sv
// Bus decoder
// Routes one request at a time to the boot ROM or the SRAM path and
// answers the GPIO hole and unmapped space with error responses

`include "soc_params.svh"

module bus_decoder import soc_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Upstream request
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  logic [`SOC_ADDR_W-1:0] req_addr_i,
  input  logic                   req_we_i,
  input  logic [`SOC_BE_W-1:0]   req_be_i,
  input  logic [`SOC_DATA_W-1:0] req_wdata_i,
  // Upstream response
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output logic [`SOC_DATA_W-1:0] rsp_data_o,
  output resp_e                  rsp_resp_o,
  // Boot ROM
  output logic                   rom_req_valid_o,
  input  logic                   rom_rsp_valid_i,
  input  logic [`SOC_DATA_W-1:0] rom_rsp_data_i,
  input  resp_e                  rom_rsp_resp_i,
  // SRAM path
  output logic                   sram_req_valid_o,
  input  logic                   sram_req_ready_i,
  input  logic                   sram_rsp_valid_i,
  output logic                   sram_rsp_ready_o,
  input  logic [`SOC_DATA_W-1:0] sram_rsp_data_i,
  input  resp_e                  sram_rsp_resp_i,
  // Request fields shared by both targets
  output logic [`SOC_ADDR_W-1:0] req_addr_o,
  output logic                   req_we_o,
  output logic [`SOC_BE_W-1:0]   req_be_o,
  output logic [`SOC_DATA_W-1:0] req_wdata_o
);

  localparam logic [`SOC_ADDR_W-1:0] RomEnd  = `SOC_ROM_BASE + `SOC_ROM_LEN;
  localparam logic [`SOC_ADDR_W-1:0] GpioEnd = `SOC_GPIO_BASE + `SOC_GPIO_LEN;
  localparam logic [`SOC_ADDR_W-1:0] SramEnd =
    `SOC_SRAM_BASE + `SOC_SRAM_WORDS * `SOC_BE_W;

  region_e                region;
  region_e                owner_q;
  logic                   outstanding_q;
  logic                   outstanding_d;
  logic                   ready_q;
  logic                   req_fire;
  logic                   rsp_fire;
  logic                   rom_req_q;
  logic                   sram_req_q;
  logic                   rsp_valid_q;
  logic                   rsp_load;
  logic [`SOC_DATA_W-1:0] rsp_data_d;
  logic [`SOC_DATA_W-1:0] rsp_data_q;
  resp_e                  rsp_resp_d;
  resp_e                  rsp_resp_q;

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------
  always_comb begin
    if (req_addr_i >= `SOC_ROM_BASE && req_addr_i < RomEnd) begin
      region = REG_ROM;
    end else if (req_addr_i >= `SOC_SRAM_BASE && req_addr_i < SramEnd) begin
      region = REG_SRAM;
    end else if (req_addr_i >= `SOC_GPIO_BASE && req_addr_i < GpioEnd) begin
      region = REG_GPIO;
    end else begin
      region = REG_NONE;
    end
  end

  assign req_fire      = req_valid_i && ready_q;
  assign rsp_fire      = rsp_valid_q && rsp_ready_i;
  assign outstanding_d = req_fire || (outstanding_q && !rsp_fire);

  // Only take from the SRAM path while its transfer is pending
  assign sram_rsp_ready_o = outstanding_q && owner_q == REG_SRAM && !rsp_valid_q;

  // Response source select
  always_comb begin
    rsp_load   = 1'b0;
    rsp_data_d = '0;
    rsp_resp_d = OKAY;
    if (req_fire && region == REG_GPIO) begin
      rsp_load   = 1'b1;
      rsp_resp_d = SLVERR;
    end else if (req_fire && region == REG_NONE) begin
      rsp_load   = 1'b1;
      rsp_resp_d = DECERR;
    end else if (rom_rsp_valid_i && outstanding_q && owner_q == REG_ROM) begin
      rsp_load   = 1'b1;
      rsp_data_d = rom_rsp_data_i;
      rsp_resp_d = rom_rsp_resp_i;
    end else if (sram_rsp_valid_i && sram_rsp_ready_o) begin
      rsp_load   = 1'b1;
      rsp_data_d = sram_rsp_data_i;
      rsp_resp_d = sram_rsp_resp_i;
    end
  end

  // --------------------------------------------------
  // Transaction tracking
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 1'b0;
      ready_q       <= 1'b0;
      owner_q       <= REG_NONE;
      rom_req_q     <= 1'b0;
      sram_req_q    <= 1'b0;
      rsp_valid_q   <= 1'b0;
    end else begin
      outstanding_q <= outstanding_d;
      ready_q       <= !outstanding_d;
      rom_req_q     <= req_fire && region == REG_ROM;
      if (req_fire) begin
        owner_q <= region;
      end
      if (req_fire && region == REG_SRAM) begin
        sram_req_q <= 1'b1;
      end else if (sram_req_ready_i) begin
        sram_req_q <= 1'b0;
      end
      if (rsp_load) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_fire) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      req_addr_o  <= req_addr_i;
      req_we_o    <= req_we_i;
      req_be_o    <= req_be_i;
      req_wdata_o <= req_wdata_i;
    end
    if (rsp_load) begin
      rsp_data_q <= rsp_data_d;
      rsp_resp_q <= rsp_resp_d;
    end
  end

  assign req_ready_o      = ready_q;
  assign rom_req_valid_o  = rom_req_q;
  assign sram_req_valid_o = sram_req_q;
  assign rsp_valid_o      = rsp_valid_q;
  assign rsp_data_o       = rsp_data_q;
  assign rsp_resp_o       = rsp_resp_q;

  // Each response belongs to an accepted request
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(rsp_valid_o) |-> outstanding_q);

endmodule

// File: design/sim_soc_top.sv
// Simulation SoC fabric
// One request port decoded to boot ROM, delayed SRAM and error regions,
// with debug reset and request control

`include "soc_params.svh"

module sim_soc_top import soc_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   ndmreset_i,
  input  logic                   debug_req_i,
  input  logic                   debug_en_i,
  output logic                   debug_req_o,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  logic [`SOC_ADDR_W-1:0] req_addr_i,
  input  logic                   req_we_i,
  input  logic [`SOC_BE_W-1:0]   req_be_i,
  input  logic [`SOC_DATA_W-1:0] req_wdata_i,
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output logic [`SOC_DATA_W-1:0] rsp_data_o,
  output resp_e                  rsp_resp_o
);

  logic                   fabric_rst_n;
  logic [`SOC_ADDR_W-1:0] tgt_addr;
  logic                   tgt_we;
  logic [`SOC_BE_W-1:0]   tgt_be;
  logic [`SOC_DATA_W-1:0] tgt_wdata;
  logic                   rom_req_valid;
  logic                   rom_rsp_valid;
  logic [`SOC_DATA_W-1:0] rom_rsp_data;
  resp_e                  rom_rsp_resp;
  logic                   sram_req_valid;
  logic                   sram_req_ready;
  logic                   sram_rsp_valid;
  logic                   sram_rsp_ready;
  mem_req_t               sram_req;
  mem_req_t               mem_req;
  logic                   mem_req_valid;
  logic                   mem_req_ready;
  mem_rsp_t               mem_rsp;
  logic                   mem_rsp_valid;
  logic                   mem_rsp_ready;
  mem_rsp_t               sram_rsp;

  debug_ctrl u_debug_ctrl (
    .clk_i         ( clk_i        ),
    .rst_ni        ( rst_ni       ),
    .ndmreset_i    ( ndmreset_i   ),
    .debug_req_i   ( debug_req_i  ),
    .debug_en_i    ( debug_en_i   ),
    .fabric_rst_no ( fabric_rst_n ),
    .debug_req_o   ( debug_req_o  )
  );

  bus_decoder u_bus_decoder (
    .clk_i            ( clk_i          ),
    .rst_ni           ( fabric_rst_n   ),
    .req_valid_i      ( req_valid_i    ),
    .req_ready_o      ( req_ready_o    ),
    .req_addr_i       ( req_addr_i     ),
    .req_we_i         ( req_we_i       ),
    .req_be_i         ( req_be_i       ),
    .req_wdata_i      ( req_wdata_i    ),
    .rsp_valid_o      ( rsp_valid_o    ),
    .rsp_ready_i      ( rsp_ready_i    ),
    .rsp_data_o       ( rsp_data_o     ),
    .rsp_resp_o       ( rsp_resp_o     ),
    .rom_req_valid_o  ( rom_req_valid  ),
    .rom_rsp_valid_i  ( rom_rsp_valid  ),
    .rom_rsp_data_i   ( rom_rsp_data   ),
    .rom_rsp_resp_i   ( rom_rsp_resp   ),
    .sram_req_valid_o ( sram_req_valid ),
    .sram_req_ready_i ( sram_req_ready ),
    .sram_rsp_valid_i ( sram_rsp_valid ),
    .sram_rsp_ready_o ( sram_rsp_ready ),
    .sram_rsp_data_i  ( sram_rsp.data  ),
    .sram_rsp_resp_i  ( sram_rsp.resp  ),
    .req_addr_o       ( tgt_addr       ),
    .req_we_o         ( tgt_we         ),
    .req_be_o         ( tgt_be         ),
    .req_wdata_o      ( tgt_wdata      )
  );

  boot_rom u_boot_rom (
    .clk_i       ( clk_i         ),
    .rst_ni      ( fabric_rst_n  ),
    .req_valid_i ( rom_req_valid ),
    .req_addr_i  ( tgt_addr      ),
    .req_we_i    ( tgt_we        ),
    .rsp_valid_o ( rom_rsp_valid ),
    .rsp_data_o  ( rom_rsp_data  ),
    .rsp_resp_o  ( rom_rsp_resp  )
  );

  // --------------------------------------------------
  // SRAM behind request and response stages
  // --------------------------------------------------
  assign sram_req = '{addr: tgt_addr, we: tgt_we, be: tgt_be, wdata: tgt_wdata};

  delay_stage #(
    .payload_t ( mem_req_t )
  ) u_req_stage (
    .clk_i       ( clk_i          ),
    .rst_ni      ( fabric_rst_n   ),
    .in_valid_i  ( sram_req_valid ),
    .in_ready_o  ( sram_req_ready ),
    .in_data_i   ( sram_req       ),
    .out_valid_o ( mem_req_valid  ),
    .out_ready_i ( mem_req_ready  ),
    .out_data_o  ( mem_req        )
  );

  sram_mem u_sram_mem (
    .clk_i       ( clk_i         ),
    .rst_ni      ( fabric_rst_n  ),
    .req_valid_i ( mem_req_valid ),
    .req_ready_o ( mem_req_ready ),
    .req_i       ( mem_req       ),
    .rsp_valid_o ( mem_rsp_valid ),
    .rsp_ready_i ( mem_rsp_ready ),
    .rsp_o       ( mem_rsp       )
  );

  delay_stage #(
    .payload_t ( mem_rsp_t )
  ) u_rsp_stage (
    .clk_i       ( clk_i          ),
    .rst_ni      ( fabric_rst_n   ),
    .in_valid_i  ( mem_rsp_valid  ),
    .in_ready_o  ( mem_rsp_ready  ),
    .in_data_i   ( mem_rsp        ),
    .out_valid_o ( sram_rsp_valid ),
    .out_ready_i ( sram_rsp_ready ),
    .out_data_o  ( sram_rsp       )
  );

endmodule

// File: bench/tb_checker.sv
// Response checker
// Reference model of the address map with a shadow SRAM; checks
// responses, the one-outstanding handshake and debug request gating

`include "soc_params.svh"

module tb_checker import soc_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   ndmreset_i,
  input  logic                   debug_req_i,
  input  logic                   debug_en_i,
  input  logic                   debug_req_out_i,
  input  logic                   req_valid_i,
  input  logic                   req_ready_i,
  input  logic [`SOC_ADDR_W-1:0] req_addr_i,
  input  logic                   req_we_i,
  input  logic [`SOC_BE_W-1:0]   req_be_i,
  input  logic [`SOC_DATA_W-1:0] req_wdata_i,
  input  logic                   rsp_valid_i,
  input  logic                   rsp_ready_i,
  input  logic [`SOC_DATA_W-1:0] rsp_data_i,
  input  resp_e                  rsp_resp_i,
  output int unsigned            err_cnt_o,
  output int unsigned            chk_cnt_o,
  output int unsigned            acc_cnt_o,
  output int unsigned            rsp_cnt_o
);

  localparam logic [31:0] SramEnd = `SOC_SRAM_BASE + `SOC_SRAM_WORDS * 8;

  int unsigned            err_cnt = 0;
  int unsigned            chk_cnt = 0;
  int unsigned            acc_cnt = 0;
  int unsigned            rsp_cnt = 0;
  int unsigned            edge_cnt = 0;
  mem_req_t               pending[$];
  logic                   held = 1'b0;
  logic [`SOC_DATA_W-1:0] held_data;
  resp_e                  held_resp;
  logic [7:0]             shadow [`SOC_SRAM_WORDS][8];
  bit                     known [`SOC_SRAM_WORDS][8];

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    err_cnt++;
    $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
  endtask

  task automatic report_error(input string what);
    err_cnt++;
    $display("error: %s at %0t", what, $time);
  endtask

  function automatic region_e region_of(input logic [31:0] addr);
    if (addr >= `SOC_ROM_BASE && addr < `SOC_ROM_BASE + `SOC_ROM_LEN) begin
      return REG_ROM;
    end else if (addr >= `SOC_GPIO_BASE && addr < `SOC_GPIO_BASE + `SOC_GPIO_LEN) begin
      return REG_GPIO;
    end else if (addr >= `SOC_SRAM_BASE && addr < SramEnd) begin
      return REG_SRAM;
    end
    return REG_NONE;
  endfunction

  // --------------------------------------------------
  // Expected response from the memory map rules
  // --------------------------------------------------
  task automatic compare_rsp(input mem_req_t req);
    logic [63:0] exp_data;
    logic [63:0] mask;
    resp_e       exp_resp;
    int unsigned w;
    exp_data = '0;
    mask     = '1;
    exp_resp = OKAY;
    case (region_of(req.addr))
      REG_ROM: begin
        w = (req.addr - `SOC_ROM_BASE) >> 3;
        if (req.we) begin
          exp_resp = SLVERR;
        end else begin
          exp_data = {`SOC_ROM_MAGIC, w};
        end
      end
      REG_SRAM: begin
        w = (req.addr - `SOC_SRAM_BASE) >> 3;
        for (int b = 0; b < 8; b++) begin
          if (req.we && req.be[b]) begin
            shadow[w][b] = req.wdata[b*8 +: 8];
            known[w][b]  = 1'b1;
          end
          if (!req.we) begin
            // Bytes never written are not compared
            exp_data[b*8 +: 8] = shadow[w][b];
            mask[b*8 +: 8]     = known[w][b] ? 8'hff : 8'h00;
          end
        end
      end
      REG_GPIO: exp_resp = SLVERR;
      default:  exp_resp = DECERR;
    endcase
    chk_cnt++;
    if (rsp_resp_i !== exp_resp) begin
      report_mismatch($sformatf("rsp_resp_o (addr %h)", req.addr), rsp_resp_i, exp_resp);
    end
    if ((rsp_data_i & mask) !== (exp_data & mask)) begin
      report_mismatch($sformatf("rsp_data_o (addr %h)", req.addr),
                      rsp_data_i & mask, exp_data & mask);
    end
  endtask

  task automatic check_bus();
    mem_req_t req;
    if (pending.size() != 0 && req_ready_i) begin
      report_error("req_ready_o high while a transaction is outstanding");
    end
    if (held && !rsp_valid_i) begin
      report_error("rsp_valid_o dropped before the response was taken");
    end else if (held) begin
      if (rsp_data_i !== held_data) begin
        report_mismatch("rsp_data_o under stall", rsp_data_i, held_data);
      end
      if (rsp_resp_i !== held_resp) begin
        report_mismatch("rsp_resp_o under stall", rsp_resp_i, held_resp);
      end
    end
    if (rsp_valid_i && pending.size() == 0) begin
      report_error("response without an accepted request");
    end else if (rsp_valid_i && rsp_ready_i) begin
      req = pending.pop_front();
      compare_rsp(req);
      rsp_cnt++;
    end
    held      = rsp_valid_i && !rsp_ready_i;
    held_data = rsp_data_i;
    held_resp = rsp_resp_i;
    if (req_valid_i && req_ready_i) begin
      req = '{addr: req_addr_i, we: req_we_i, be: req_be_i, wdata: req_wdata_i};
      pending.push_back(req);
      acc_cnt++;
    end
  endtask

  // --------------------------------------------------
  // Sampling on the rising edge
  // --------------------------------------------------
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      edge_cnt = 0;
    end else begin
      // Gate opens after the hold window, ndmreset does not restart it
      if (debug_req_out_i !== (edge_cnt >= `SOC_DBG_HOLD && debug_req_i && debug_en_i)) begin
        report_mismatch("debug_req_o", debug_req_out_i,
                        edge_cnt >= `SOC_DBG_HOLD && debug_req_i && debug_en_i);
      end
      if (edge_cnt < `SOC_DBG_HOLD) begin
        edge_cnt++;
      end
    end
    if (!rst_ni || ndmreset_i) begin
      if (req_ready_i !== 1'b0) begin
        report_error("req_ready_o not low during reset");
      end
      if (rsp_valid_i !== 1'b0) begin
        report_error("rsp_valid_o not low during reset");
      end
      pending.delete();
      held = 1'b0;
    end else begin
      check_bus();
    end
  end

  assign err_cnt_o = err_cnt;
  assign chk_cnt_o = chk_cnt;
  assign acc_cnt_o = acc_cnt;
  assign rsp_cnt_o = rsp_cnt;

endmodule

// File: bench/tb_top.sv
// Testbench top for the simulation SoC fabric
// Clock, reset, seeded random traffic, ndmreset pulse and watchdog

`include "soc_params.svh"

module tb_top import soc_pkg::*; ();

  localparam int unsigned RandTxn     = 300;
  localparam int unsigned ReadbackTxn = 32;
  localparam int unsigned TotalTxn    = 2 * RandTxn + ReadbackTxn;
  localparam int unsigned WdogCycles  = TotalTxn * 40 + `SOC_DBG_HOLD + 200;
  localparam logic [31:0] Seed        = 32'hd490_8881;

  logic                   clk = 1'b1;
  logic                   rst_n;
  logic                   ndmreset;
  logic                   debug_req;
  logic                   debug_en;
  logic                   debug_req_out;
  logic                   req_valid;
  logic                   req_ready;
  logic [`SOC_ADDR_W-1:0] req_addr;
  logic                   req_we;
  logic [`SOC_BE_W-1:0]   req_be;
  logic [`SOC_DATA_W-1:0] req_wdata;
  logic                   rsp_valid;
  logic                   rsp_ready;
  logic [`SOC_DATA_W-1:0] rsp_data;
  resp_e                  rsp_resp;
  int unsigned            err_cnt;
  int unsigned            chk_cnt;
  int unsigned            acc_cnt;
  int unsigned            rsp_cnt;
  int unsigned            issued;

  always #10 clk = ~clk;

  sim_soc_top u_dut (
    .clk_i       ( clk           ),
    .rst_ni      ( rst_n         ),
    .ndmreset_i  ( ndmreset      ),
    .debug_req_i ( debug_req     ),
    .debug_en_i  ( debug_en      ),
    .debug_req_o ( debug_req_out ),
    .req_valid_i ( req_valid     ),
    .req_ready_o ( req_ready     ),
    .req_addr_i  ( req_addr      ),
    .req_we_i    ( req_we        ),
    .req_be_i    ( req_be        ),
    .req_wdata_i ( req_wdata     ),
    .rsp_valid_o ( rsp_valid     ),
    .rsp_ready_i ( rsp_ready     ),
    .rsp_data_o  ( rsp_data      ),
    .rsp_resp_o  ( rsp_resp      )
  );

  tb_checker u_chk (
    .clk_i           ( clk           ),
    .rst_ni          ( rst_n         ),
    .ndmreset_i      ( ndmreset      ),
    .debug_req_i     ( debug_req     ),
    .debug_en_i      ( debug_en      ),
    .debug_req_out_i ( debug_req_out ),
    .req_valid_i     ( req_valid     ),
    .req_ready_i     ( req_ready     ),
    .req_addr_i      ( req_addr      ),
    .req_we_i        ( req_we        ),
    .req_be_i        ( req_be        ),
    .req_wdata_i     ( req_wdata     ),
    .rsp_valid_i     ( rsp_valid     ),
    .rsp_ready_i     ( rsp_ready     ),
    .rsp_data_i      ( rsp_data      ),
    .rsp_resp_i      ( rsp_resp      ),
    .err_cnt_o       ( err_cnt       ),
    .chk_cnt_o       ( chk_cnt       ),
    .acc_cnt_o       ( acc_cnt       ),
    .rsp_cnt_o       ( rsp_cnt       )
  );

  // Weighted region pick, SRAM traffic mostly on a few words
  function automatic logic [`SOC_ADDR_W-1:0] pick_addr();
    int unsigned sel;
    int unsigned idx;
    sel = $urandom % 20;
    if (sel < 10) begin
      idx = ($urandom % 8 == 0) ? $urandom % `SOC_SRAM_WORDS : $urandom % 32;
      return `SOC_SRAM_BASE + idx * 8 + $urandom % 8;
    end else if (sel < 14) begin
      return `SOC_ROM_BASE + $urandom % `SOC_ROM_LEN;
    end else if (sel < 17) begin
      return `SOC_GPIO_BASE + $urandom % `SOC_GPIO_LEN;
    end
    case ($urandom % 3)
      0:       return $urandom % `SOC_ROM_BASE;
      1:       return `SOC_SRAM_BASE + `SOC_SRAM_WORDS * 8 + $urandom % 32'h1000;
      default: return 32'hC000_0000 + $urandom % 32'h1000_0000;
    endcase
  endfunction

  // Holds the request until accepted, returns on the next falling edge
  task automatic send_req(input logic [`SOC_ADDR_W-1:0] addr, input logic we);
    req_addr  = addr;
    req_we    = we;
    req_be    = 8'($urandom);
    req_wdata = {$urandom, $urandom};
    req_valid = 1'b1;
    while (!req_ready) begin
      @(negedge clk);
    end
    @(negedge clk);
    req_valid = 1'b0;
    issued++;
  endtask

  task automatic run_random(input int unsigned n);
    for (int unsigned i = 0; i < n; i++) begin
      send_req(pick_addr(), 1'($urandom % 2));
    end
  endtask

  // Response stalls and debug inputs
  task automatic drive_background();
    logic [31:0] r;
    forever begin
      @(negedge clk);
      r         = $urandom;
      rsp_ready = r[1:0] != 2'b00;
      debug_req = r[2];
      debug_en  = r[4:3] != 2'b00;
    end
  endtask

  task automatic watchdog();
    repeat (WdogCycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", WdogCycles);
    $display("*** FAILED ***");
    $finish;
  endtask

  task automatic pulse_ndmreset();
    while (!req_ready) begin
      @(negedge clk);
    end
    ndmreset = 1'b1;
    repeat (3) @(negedge clk);
    ndmreset = 1'b0;
  endtask

  initial begin : main
    int unsigned errors;
    void'($urandom(Seed));
    rst_n     = 1'b1;
    ndmreset  = 1'b0;
    debug_req = 1'b0;
    debug_en  = 1'b0;
    req_valid = 1'b0;
    req_addr  = '0;
    req_we    = 1'b0;
    req_be    = '0;
    req_wdata = '0;
    rsp_ready = 1'b0;
    issued    = 0;
    fork
      drive_background();
      watchdog();
    join_none
    @(negedge clk);
    rst_n = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    run_random(RandTxn);
    pulse_ndmreset();
    // Earlier SRAM writes must survive the fabric reset
    for (int unsigned w = 0; w < ReadbackTxn; w++) begin
      send_req(`SOC_SRAM_BASE + w * 8, 1'b0);
    end
    run_random(RandTxn);
    while (!req_ready) begin
      @(negedge clk);
    end

    errors = err_cnt;
    if (acc_cnt != issued || rsp_cnt != acc_cnt) begin
      $display("error: %0d requests issued, %0d accepted, %0d responses",
               issued, acc_cnt, rsp_cnt);
      errors++;
    end
    $display("checks %0d, errors %0d, requests %0d, responses %0d",
             chk_cnt, errors, acc_cnt, rsp_cnt);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: sim_soc.f
+incdir+design
design/soc_pkg.sv
design/delay_stage.sv
design/sram_mem.sv
design/boot_rom.sv
design/debug_ctrl.sv
design/bus_decoder.sv
design/sim_soc_top.sv
bench/tb_checker.sv
bench/tb_top.sv

// File: Makefile
# Verilator build for the simulation SoC fabric

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_top
FILELIST  := sim_soc.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF -- '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
